// ==== dv/lc4_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc4_monitor import lc4_pkg::*; #(
   parameter word_t RESET_PC  = 16'h8200,
   parameter int    NUM_INSNS = 200,
   parameter int    DENSE_END = 60,
   parameter int    INDEP_END = 120
) (
   input  wire          gwe,
   input  wire          i_arst_n,
   input  wire commit_t i_commit_a,
   input  wire commit_t i_commit_b,
   input  wire          i_dmem_we,
   input  wire word_t   i_dmem_addr,
   input  wire word_t   i_dmem_towrite,
   output logic         o_done,
   output int           o_errors
);

   word_t prog [NUM_INSNS];    // filled by the testbench
   word_t mdata [65536];
   word_t mregs [NUM_REGS];
   word_t mpc;
   int    n_commits;
   int    test_idx;
   int    test_errors;
   int    dual_commits;
   word_t strobe_addr [$];
   word_t strobe_data [$];
   string test_name [4] = '{"reset", "dense", "independent", "mixed"};
   int    test_end [4]  = '{0, DENSE_END, INDEP_END, NUM_INSNS};

   // what the ISA says one instruction retires
   function automatic commit_t expected(input word_t pc, input word_t insn);
      commit_t e;
      word_t   a;
      word_t   b;
      word_t   imm5;
      word_t   imm6;
      e      = '0;
      e.valid = 1'b1;
      e.pc    = pc;
      e.insn  = insn;
      e.wsel  = insn[11:9];
      a       = mregs[insn[8:6]];
      b       = mregs[insn[2:0]];
      imm5    = {{11{insn[4]}}, insn[4:0]};
      imm6    = {{10{insn[5]}}, insn[5:0]};
      case (insn[15:12])
         4'b0001: begin
            e.rf_we = insn[5] || !insn[3];    // add, sub, add imm
            e.wdata = insn[5] ? a + imm5 : (insn[4] ? a - b : a + b);
         end
         4'b0101: begin
            e.rf_we = 1'b1;
            if (insn[5]) e.wdata = a & imm5;
            else case (insn[4:3])
               2'b00:   e.wdata = a & b;
               2'b01:   e.wdata = ~a;
               2'b10:   e.wdata = a | b;
               default: e.wdata = a ^ b;
            endcase
         end
         4'b0110: begin
            e.rf_we     = 1'b1;
            e.dmem_addr = a + imm6;
            e.dmem_data = mdata[e.dmem_addr];
            e.wdata     = e.dmem_data;
         end
         4'b0111: begin
            e.dmem_we   = 1'b1;
            e.dmem_addr = a + imm6;
            e.dmem_data = mregs[insn[11:9]];
         end
         4'b1001: begin
            e.rf_we = 1'b1;
            e.wdata = {{7{insn[8]}}, insn[8:0]};
         end
         default: ;
      endcase
      if (!e.rf_we) begin
         e.wsel  = '0;
         e.wdata = '0;
      end
      return e;
   endfunction

   function automatic logic [7:0] read_mask(input word_t insn);
      logic [7:0] m;
      m = '0;
      case (insn[15:12])
         4'b0001: begin
            m[insn[8:6]] = insn[5] || !insn[3];
            if (!insn[5] && !insn[3]) m[insn[2:0]] = 1'b1;
         end
         4'b0101: begin
            m[insn[8:6]] = 1'b1;
            if (!insn[5] && insn[4:3] != 2'b01) m[insn[2:0]] = 1'b1;
         end
         4'b0110: m[insn[8:6]] = 1'b1;
         4'b0111: begin
            m[insn[8:6]]  = 1'b1;
            m[insn[11:9]] = 1'b1;    // store data
         end
         default: ;
      endcase
      return m;
   endfunction

   task automatic report(input string what);
      $display("%0t: %s", $time, what);
      test_errors++;
      o_errors++;
   endtask

   task automatic compare(input string lane, input string field, input word_t got,
                          input word_t exp);
      if (got !== exp) begin
         $display("Fail %0t lane %s %s got %h expected %h", $time, lane, field, got, exp);
         test_errors++;
         o_errors++;
      end
   endtask

   task automatic finish_test();
      if (test_idx == 2 && dual_commits == 0)
         report("no cycle committed both lanes in the independent section");
      $display("test %s done: %0d errors", test_name[test_idx], test_errors);
      test_idx++;
      test_errors  = 0;
      dual_commits = 0;
      if (test_idx == 4) begin
         $display("commits %0d, errors %0d", n_commits, o_errors);
         o_done = 1'b1;
      end
   endtask

   task automatic check_lane(input string lane, input commit_t got, output commit_t e);
      word_t insn;
      int    idx;
      idx  = int'(mpc - RESET_PC);
      insn = (idx < NUM_INSNS) ? prog[idx] : '0;
      e    = expected(mpc, insn);
      compare(lane, "pc", got.pc, e.pc);
      compare(lane, "insn", got.insn, e.insn);
      compare(lane, "rf_we", 16'(got.rf_we), 16'(e.rf_we));
      compare(lane, "wsel", 16'(got.wsel), 16'(e.wsel));
      compare(lane, "wdata", got.wdata, e.wdata);
      compare(lane, "dmem_we", 16'(got.dmem_we), 16'(e.dmem_we));
      compare(lane, "dmem_addr", got.dmem_addr, e.dmem_addr);
      compare(lane, "dmem_data", got.dmem_data, e.dmem_data);
      if (e.dmem_we) begin
         if (strobe_addr.size() == 0) begin
            report("store committed without a data memory write strobe");
         end else begin
            compare(lane, "o_dmem_addr", strobe_addr.pop_front(), e.dmem_addr);
            compare(lane, "o_dmem_towrite", strobe_data.pop_front(), e.dmem_data);
         end
         mdata[e.dmem_addr] = e.dmem_data;
      end
      if (e.rf_we) mregs[e.wsel] = e.wdata;
      mpc++;
      n_commits++;
      if (n_commits == test_end[test_idx]) finish_test();
   endtask

   initial begin
      commit_t    ea;
      commit_t    eb;
      logic [7:0] mask;
      o_done       = 1'b0;
      o_errors     = 0;
      mpc          = RESET_PC;
      n_commits    = 0;
      test_idx     = 0;
      test_errors  = 0;
      dual_commits = 0;
      for (int r = 0; r < NUM_REGS; r++) mregs[r] = '0;
      forever begin
         @(posedge gwe);
         if (o_done) begin
         end else if (!i_arst_n) begin
            if (i_commit_a.valid || i_commit_b.valid)
               report("commit valid while reset is asserted");
         end else begin
            if (test_idx == 0) finish_test();    // first cycle out of reset
            ea = '0;
            if (i_commit_a.valid) check_lane("A", i_commit_a, ea);
            if (i_commit_b.valid && !o_done) begin
               if (!i_commit_a.valid) report("lane B committed without lane A");
               check_lane("B", i_commit_b, eb);
               mask = read_mask(eb.insn);
               if (ea.rf_we && mask[ea.wsel])
                  report("lane B read lane A's destination in the same cycle");
               if (i_commit_a.valid) dual_commits++;
            end
            // each strobe is matched by its store commit one cycle later
            if (strobe_addr.size() != 0) begin
               report("write strobe without a matching store");
               strobe_addr.delete();
               strobe_data.delete();
            end
            if (i_dmem_we) begin
               strobe_addr.push_back(i_dmem_addr);
               strobe_data.push_back(i_dmem_towrite);
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== dv/lc4_pipe_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc4_pipe_chk import lc4_pkg::*; (
   input wire          gwe,
   input wire          i_arst_n,
   input wire commit_t i_commit_a,
   input wire commit_t i_commit_b,
   input wire          i_dmem_we
);

   int n_fail = 0;    // failed assertions so far

   b_needs_a: assert property (@(posedge gwe) disable iff (!i_arst_n)
      i_commit_b.valid |-> i_commit_a.valid)
      else begin
         $error("lane B committed alone");
         n_fail++;
      end

   // same-cycle pair is consecutive in program order
   pair_pc: assert property (@(posedge gwe) disable iff (!i_arst_n)
      (i_commit_a.valid && i_commit_b.valid) |-> i_commit_b.pc == i_commit_a.pc + 16'd1)
      else begin
         $error("lane B pc does not follow lane A");
         n_fail++;
      end

   no_mem_b: assert property (@(posedge gwe) disable iff (!i_arst_n)
      i_commit_b.valid |-> (i_commit_b.insn[15:13] != 3'b011) && !i_commit_b.dmem_we)
      else begin
         $error("memory instruction committed in lane B");
         n_fail++;
      end

   quiet_reset: assert property (@(posedge gwe) !i_arst_n |-> !i_dmem_we)
      else begin
         $error("data memory write during reset");
         n_fail++;
      end

endmodule

bind lc4_superscalar lc4_pipe_chk u_pipe_chk (
   .gwe(gwe),
   .i_arst_n(i_arst_n),
   .i_commit_a(o_commit_a),
   .i_commit_b(o_commit_b),
   .i_dmem_we(o_dmem_we)
);

`default_nettype wire

// ==== dv/tb_lc4.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lc4 import lc4_pkg::*; ();

   localparam word_t RESET_PC       = 16'h8200;
   localparam int    NUM_INSNS      = 200;
   localparam int    DENSE_END      = 60;     // r0-r2 only
   localparam int    INDEP_END      = 120;    // reads r0-r3, writes r4-r7
   localparam int    TIMEOUT_CYCLES = 3000;

   logic    gwe;
   logic    arst_n;
   word_t   cur_pc;
   word_t   insn_a;
   word_t   insn_b;
   word_t   dmem_addr;
   word_t   dmem_towrite;
   word_t   dmem_data;
   logic    dmem_we;
   commit_t commit_a;
   commit_t commit_b;
   logic    done;
   int      errors;

   word_t imem [65536];
   word_t dmem [65536];

   lc4_superscalar #(.RESET_PC(RESET_PC)) i_dut (
      .gwe(gwe), .i_arst_n(arst_n),
      .o_cur_pc(cur_pc), .i_cur_insn_a(insn_a), .i_cur_insn_b(insn_b),
      .o_dmem_addr(dmem_addr), .o_dmem_we(dmem_we), .o_dmem_towrite(dmem_towrite),
      .i_dmem_data(dmem_data),
      .o_commit_a(commit_a), .o_commit_b(commit_b)
   );

   lc4_monitor #(
      .RESET_PC(RESET_PC), .NUM_INSNS(NUM_INSNS),
      .DENSE_END(DENSE_END), .INDEP_END(INDEP_END)
   ) i_mon (
      .gwe(gwe), .i_arst_n(arst_n),
      .i_commit_a(commit_a), .i_commit_b(commit_b),
      .i_dmem_we(dmem_we), .i_dmem_addr(dmem_addr), .i_dmem_towrite(dmem_towrite),
      .o_done(done), .o_errors(errors)
   );

   // memory models with combinational reads
   assign insn_a    = imem[cur_pc];
   assign insn_b    = imem[cur_pc + 16'd1];
   assign dmem_data = dmem[dmem_addr];

   always @(posedge gwe) begin
      if (dmem_we) dmem[dmem_addr] <= dmem_towrite;
   end

   initial begin
      gwe = 1'b0;
      forever #4 gwe = ~gwe;
   end

   function automatic word_t alu_insn(input int d_lo, input int d_hi, input int s_lo,
                                      input int s_hi);
      reg_sel_t rd;
      reg_sel_t rs;
      reg_sel_t rt;
      word_t    w;
      rd = reg_sel_t'($urandom_range(d_hi, d_lo));
      rs = reg_sel_t'($urandom_range(s_hi, s_lo));
      rt = reg_sel_t'($urandom_range(s_hi, s_lo));
      case ($urandom_range(9, 0))
         0:       w = {4'b0001, rd, rs, 3'b000, rt};              // add
         1:       w = {4'b0001, rd, rs, 3'b010, rt};              // sub
         2:       w = {4'b0001, rd, rs, 1'b1, 5'($urandom())};    // add imm
         3:       w = {4'b0101, rd, rs, 3'b000, rt};
         4:       w = {4'b0101, rd, rs, 3'b001, rt};              // not
         5:       w = {4'b0101, rd, rs, 3'b010, rt};
         6:       w = {4'b0101, rd, rs, 3'b011, rt};
         7:       w = {4'b0101, rd, rs, 1'b1, 5'($urandom())};
         default: w = {4'b1001, rd, 9'($urandom())};              // const
      endcase
      return w;
   endfunction

   function automatic word_t unknown_insn();
      logic [3:0] bad_ops [9] = '{4'h0, 4'h2, 4'h3, 4'h4, 4'h8, 4'hA, 4'hC, 4'hD, 4'hF};
      word_t      w;
      w = word_t'($urandom());
      case ($urandom_range(3, 0))
         0:       w = '0;
         1:       w = {4'b0001, w[11:6], 3'b001, w[2:0]};    // mul is not supported
         default: w[15:12] = bad_ops[$urandom_range(8, 0)];
      endcase
      return w;
   endfunction

   // loads and stores use r7 as base, set by a const at the section start
   function automatic word_t mem_insn();
      if ($urandom_range(1, 0) == 0)
         return {4'b0110, 3'($urandom_range(6, 0)), 3'd7, 6'($urandom())};
      return {4'b0111, 3'($urandom_range(7, 0)), 3'd7, 6'($urandom())};
   endfunction

   initial begin
      word_t w;
      int    cycles;
      arst_n = 1'b0;
      void'($urandom(32'h7398_90ff));
      for (int a = 0; a < 65536; a++) begin
         imem[a]         = '0;
         dmem[a]         = word_t'(a * 40503) ^ 16'h3c5a;
         i_mon.mdata[a]  = dmem[a];
      end
      for (int i = 0; i < NUM_INSNS; i++) begin
         if (i == INDEP_END)
            w = {4'b1001, 3'd7, 9'($urandom())};
         else if ($urandom_range(9, 0) == 0)
            w = unknown_insn();
         else if (i < DENSE_END)
            w = alu_insn(0, 2, 0, 2);
         else if (i < INDEP_END)
            w = alu_insn(4, 7, 0, 3);
         else if ($urandom_range(1, 0) == 0)
            w = mem_insn();
         else
            w = alu_insn(0, 6, 0, 7);
         imem[RESET_PC + i] = w;
         i_mon.prog[i]      = w;
      end
      repeat (2) @(negedge gwe);
      arst_n = 1'b1;
      cycles = 0;
      while (!done && cycles < TIMEOUT_CYCLES) begin
         @(negedge gwe);
         cycles++;
      end
      if (!done) begin
         $display("timeout after %0d cycles, not all instructions committed", cycles);
         $display("TEST FAIL");
      end else if (errors != 0 || i_dut.u_pipe_chk.n_fail != 0) begin
         $display("TEST FAIL");
      end else begin
         $display("TEST PASS");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
source/lc4_pkg.sv
source/lc4_fetch.sv
source/lc4_decoder.sv
source/lc4_regfile.sv
source/lc4_issue.sv
source/lc4_alu.sv
source/lc4_superscalar.sv
dv/lc4_pipe_chk.sv
dv/lc4_monitor.sv
dv/tb_lc4.sv

// ==== source/lc4_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc4_alu import lc4_pkg::*; (
   input  wire decoded_t i_dec,
   input  wire word_t    i_rs_data,
   input  wire word_t    i_rt_data,
   output word_t         o_result
);

   word_t opnd_b;

   assign opnd_b = i_dec.use_imm ? i_dec.imm : i_rt_data;

   // loads and stores decode as ALU_ADD with imm6, giving rs + offset
   always_comb begin
      case (i_dec.alu_op)
         ALU_ADD:    o_result = i_rs_data + opnd_b;
         ALU_SUB:    o_result = i_rs_data - opnd_b;
         ALU_AND:    o_result = i_rs_data & opnd_b;
         ALU_NOT:    o_result = ~i_rs_data;
         ALU_OR:     o_result = i_rs_data | opnd_b;
         ALU_XOR:    o_result = i_rs_data ^ opnd_b;
         ALU_PASS_B: o_result = opnd_b;
         default:    o_result = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== source/lc4_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc4_decoder import lc4_pkg::*; (
   input  wire word_t i_insn,
   input  wire        i_valid,
   output decoded_t   o_dec
);

   opcode_e op;
   word_t   imm5;
   word_t   imm6;
   word_t   imm9;

   assign op   = opcode_e'(i_insn[15:12]);
   assign imm5 = {{11{i_insn[4]}}, i_insn[4:0]};
   assign imm6 = {{10{i_insn[5]}}, i_insn[5:0]};
   assign imm9 = {{7{i_insn[8]}}, i_insn[8:0]};

   always_comb begin
      o_dec        = '0;
      o_dec.valid  = i_valid;    // no-ops still commit
      o_dec.alu_op = ALU_ADD;
      o_dec.rs     = i_insn[8:6];
      o_dec.rt     = i_insn[2:0];
      o_dec.rd     = i_insn[11:9];
      if (i_valid) begin
         case (op)
            OP_ARITH: begin
               if (i_insn[5]) begin    // add immediate
                  o_dec.rs_re   = 1'b1;
                  o_dec.rd_we   = 1'b1;
                  o_dec.use_imm = 1'b1;
                  o_dec.imm     = imm5;
               end else if (!i_insn[3]) begin    // mul and div fall through as no-ops
                  o_dec.rs_re  = 1'b1;
                  o_dec.rt_re  = 1'b1;
                  o_dec.rd_we  = 1'b1;
                  o_dec.alu_op = i_insn[4] ? ALU_SUB : ALU_ADD;
               end
            end
            OP_LOGIC: begin
               o_dec.rs_re = 1'b1;
               o_dec.rd_we = 1'b1;
               if (i_insn[5]) begin
                  o_dec.alu_op  = ALU_AND;
                  o_dec.use_imm = 1'b1;
                  o_dec.imm     = imm5;
               end else begin
                  o_dec.rt_re = (i_insn[4:3] != 2'b01);    // NOT has one source
                  case (i_insn[4:3])
                     2'b00:   o_dec.alu_op = ALU_AND;
                     2'b01:   o_dec.alu_op = ALU_NOT;
                     2'b10:   o_dec.alu_op = ALU_OR;
                     default: o_dec.alu_op = ALU_XOR;
                  endcase
               end
            end
            OP_LDR: begin
               o_dec.rs_re   = 1'b1;
               o_dec.rd_we   = 1'b1;
               o_dec.use_imm = 1'b1;
               o_dec.imm     = imm6;
               o_dec.is_load = 1'b1;
            end
            OP_STR: begin
               o_dec.rs_re    = 1'b1;
               o_dec.rt       = i_insn[11:9];    // store data sits in the rd field
               o_dec.rt_re    = 1'b1;
               o_dec.use_imm  = 1'b1;
               o_dec.imm      = imm6;
               o_dec.is_store = 1'b1;
            end
            OP_CONST: begin
               o_dec.rd_we   = 1'b1;
               o_dec.use_imm = 1'b1;
               o_dec.imm     = imm9;
               o_dec.alu_op  = ALU_PASS_B;
            end
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== source/lc4_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc4_fetch import lc4_pkg::*; #(
   parameter word_t RESET_PC = 16'h8200
) (
   input  wire        gwe,
   input  wire        i_arst_n,
   input  wire word_t i_insn_a,      // imem[pc]
   input  wire word_t i_insn_b,      // imem[pc+1]
   input  wire        i_take_a,
   input  wire        i_take_b,
   output word_t      o_pc,
   output word_t      o_pair_insn_a,
   output word_t      o_pair_insn_b,
   output word_t      o_pair_pc_a,
   output word_t      o_pair_pc_b,
   output logic       o_pair_valid_a,
   output logic       o_pair_valid_b
);

   word_t pc_plus_one;

   assign pc_plus_one = o_pc + 16'd1;

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_pc           <= RESET_PC;
         o_pair_valid_a <= 1'b0;    // empty pair, so the first cycle takes both slots
         o_pair_valid_b <= 1'b0;
      end else if (i_take_a && i_take_b) begin
         o_pc           <= o_pc + 16'd2;
         o_pair_valid_a <= 1'b1;
         o_pair_valid_b <= 1'b1;
      end else if (i_take_a) begin
         o_pc           <= pc_plus_one;
         o_pair_valid_a <= o_pair_valid_b;
         o_pair_valid_b <= 1'b1;
      end
   end

   // pair contents; note pair_pc_b + 1 always equals pc
   always_ff @(posedge gwe) begin
      if (i_take_a && i_take_b) begin
         o_pair_insn_a <= i_insn_a;
         o_pair_pc_a   <= o_pc;
         o_pair_insn_b <= i_insn_b;
         o_pair_pc_b   <= pc_plus_one;
      end else if (i_take_a) begin
         o_pair_insn_a <= o_pair_insn_b;    // held-back B moves up to the older slot
         o_pair_pc_a   <= o_pair_pc_b;
         o_pair_insn_b <= i_insn_a;
         o_pair_pc_b   <= o_pc;
      end
   end

endmodule

`default_nettype wire

// ==== source/lc4_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc4_issue import lc4_pkg::*; (
   input  wire decoded_t i_dec_a,    // decode pair, A is older
   input  wire decoded_t i_dec_b,
   input  wire decoded_t i_ex_a,
   input  wire decoded_t i_ex_b,
   input  wire decoded_t i_mem_a,
   input  wire decoded_t i_mem_b,
   output logic          o_take_a,
   output logic          o_take_b
);

   logic stall_a;
   logic hold_b;
   logic waw_ab;

   // consumer reads a register the producer will write
   function automatic logic raw(input decoded_t cons, input decoded_t prod);
      return prod.valid && prod.rd_we &&
             ((cons.rs_re && cons.rs == prod.rd) ||
              (cons.rt_re && cons.rt == prod.rd));
   endfunction

   // write-back is covered by the register file bypass, so only ex and mem count
   assign stall_a = raw(i_dec_a, i_ex_a) || raw(i_dec_a, i_ex_b) ||
                    raw(i_dec_a, i_mem_a) || raw(i_dec_a, i_mem_b);

   assign waw_ab = i_dec_a.rd_we && i_dec_b.rd_we && (i_dec_a.rd == i_dec_b.rd);

   assign hold_b = raw(i_dec_b, i_ex_a) || raw(i_dec_b, i_ex_b) ||
                   raw(i_dec_b, i_mem_a) || raw(i_dec_b, i_mem_b) ||
                   raw(i_dec_b, i_dec_a) || waw_ab ||
                   i_dec_b.is_load || i_dec_b.is_store;    // dmem port belongs to lane A

   assign o_take_a = !stall_a;
   assign o_take_b = o_take_a && !hold_b;    // never overtake A

endmodule

`default_nettype wire

// ==== source/lc4_pkg.sv ====
`default_nettype none

package lc4_pkg;

   localparam int NUM_REGS = 8;

   typedef logic [15:0] word_t;    // data, address or instruction
   typedef logic [2:0]  reg_sel_t;

   // top four bits of the instruction, anything else is a no-op
   typedef enum logic [3:0] {
      OP_ARITH = 4'b0001,
      OP_LOGIC = 4'b0101,
      OP_LDR   = 4'b0110,
      OP_STR   = 4'b0111,
      OP_CONST = 4'b1001
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_NOT,
      ALU_OR,
      ALU_XOR,
      ALU_PASS_B    // second operand straight through, for CONST
   } alu_op_e;

   // one decoded instruction, all enables low for bubbles and no-ops
   typedef struct packed {
      logic     valid;
      alu_op_e  alu_op;
      reg_sel_t rs;
      logic     rs_re;
      reg_sel_t rt;
      logic     rt_re;
      reg_sel_t rd;
      logic     rd_we;
      logic     use_imm;
      word_t    imm;       // sign-extended
      logic     is_load;
      logic     is_store;
   } decoded_t;

   // what one lane retires in a cycle
   typedef struct packed {
      logic     valid;
      word_t    pc;
      word_t    insn;
      logic     rf_we;
      reg_sel_t wsel;
      word_t    wdata;
      logic     dmem_we;
      word_t    dmem_addr;
      word_t    dmem_data;   // store data or loaded value
   } commit_t;

endpackage

`default_nettype wire

// ==== source/lc4_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc4_regfile import lc4_pkg::*; (
   input  wire           gwe,
   input  wire           i_arst_n,
   input  wire reg_sel_t i_rs_a,
   input  wire reg_sel_t i_rt_a,
   input  wire reg_sel_t i_rs_b,
   input  wire reg_sel_t i_rt_b,
   output word_t         o_rs_data_a,
   output word_t         o_rt_data_a,
   output word_t         o_rs_data_b,
   output word_t         o_rt_data_b,
   input  wire commit_t  i_wr_a,    // write-back of lane A
   input  wire commit_t  i_wr_b
);

   word_t regs [NUM_REGS];
   logic  we_a;
   logic  we_b;

   assign we_a = i_wr_a.valid && i_wr_a.rf_we;
   assign we_b = i_wr_b.valid && i_wr_b.rf_we;

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else begin
         if (we_a) regs[i_wr_a.wsel] <= i_wr_a.wdata;
         if (we_b) regs[i_wr_b.wsel] <= i_wr_b.wdata;
      end
   end

   // same-cycle write shows through, lane B checked first
   function automatic word_t read_port(input reg_sel_t sel);
      if (we_b && i_wr_b.wsel == sel) return i_wr_b.wdata;
      if (we_a && i_wr_a.wsel == sel) return i_wr_a.wdata;
      return regs[sel];
   endfunction

   always_comb begin
      o_rs_data_a = read_port(i_rs_a);
      o_rt_data_a = read_port(i_rt_a);
      o_rs_data_b = read_port(i_rs_b);
      o_rt_data_b = read_port(i_rt_b);
   end

endmodule

`default_nettype wire

// ==== source/lc4_superscalar.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc4_superscalar import lc4_pkg::*; #(
   parameter word_t RESET_PC = 16'h8200
) (
   input  wire        gwe,
   input  wire        i_arst_n,
   output word_t      o_cur_pc,
   input  wire word_t i_cur_insn_a,
   input  wire word_t i_cur_insn_b,
   output word_t      o_dmem_addr,
   output logic       o_dmem_we,
   output word_t      o_dmem_towrite,
   input  wire word_t i_dmem_data,
   output commit_t    o_commit_a,
   output commit_t    o_commit_b
);

   // index 0 is lane A, 1 is lane B
   word_t      pair_insn [2];
   word_t      pair_pc [2];
   logic [1:0] pair_valid;
   logic [1:0] take;
   decoded_t   dec [2];
   word_t      rs_data [2];
   word_t      rt_data [2];
   decoded_t   ex_dec [2];    // zero means bubble
   word_t      ex_pc [2];
   word_t      ex_insn [2];
   word_t      ex_rs_data [2];
   word_t      ex_rt_data [2];
   word_t      alu_result [2];
   decoded_t   mem_dec [2];
   word_t      mem_pc [2];
   word_t      mem_insn [2];
   word_t      mem_result [2];
   word_t      mem_rt_data [2];
   commit_t    mem_commit [2];
   commit_t    wb_commit [2];

   lc4_fetch #(.RESET_PC(RESET_PC)) u_fetch (
      .gwe(gwe), .i_arst_n(i_arst_n),
      .i_insn_a(i_cur_insn_a), .i_insn_b(i_cur_insn_b),
      .i_take_a(take[0]), .i_take_b(take[1]),
      .o_pc(o_cur_pc),
      .o_pair_insn_a(pair_insn[0]), .o_pair_insn_b(pair_insn[1]),
      .o_pair_pc_a(pair_pc[0]), .o_pair_pc_b(pair_pc[1]),
      .o_pair_valid_a(pair_valid[0]), .o_pair_valid_b(pair_valid[1])
   );

   lc4_decoder u_dec_a (.i_insn(pair_insn[0]), .i_valid(pair_valid[0]), .o_dec(dec[0]));
   lc4_decoder u_dec_b (.i_insn(pair_insn[1]), .i_valid(pair_valid[1]), .o_dec(dec[1]));

   lc4_regfile u_regfile (
      .gwe(gwe), .i_arst_n(i_arst_n),
      .i_rs_a(dec[0].rs), .i_rt_a(dec[0].rt), .i_rs_b(dec[1].rs), .i_rt_b(dec[1].rt),
      .o_rs_data_a(rs_data[0]), .o_rt_data_a(rt_data[0]),
      .o_rs_data_b(rs_data[1]), .o_rt_data_b(rt_data[1]),
      .i_wr_a(wb_commit[0]), .i_wr_b(wb_commit[1])
   );

   lc4_issue u_issue (
      .i_dec_a(dec[0]), .i_dec_b(dec[1]),
      .i_ex_a(ex_dec[0]), .i_ex_b(ex_dec[1]),
      .i_mem_a(mem_dec[0]), .i_mem_b(mem_dec[1]),
      .o_take_a(take[0]), .o_take_b(take[1])
   );

   lc4_alu u_alu_a (.i_dec(ex_dec[0]), .i_rs_data(ex_rs_data[0]), .i_rt_data(ex_rt_data[0]),
                    .o_result(alu_result[0]));
   lc4_alu u_alu_b (.i_dec(ex_dec[1]), .i_rs_data(ex_rs_data[1]), .i_rt_data(ex_rt_data[1]),
                    .o_result(alu_result[1]));

   // stage control, a lane not taken enters execute as a bubble
   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int l = 0; l < 2; l++) begin
            ex_dec[l]    <= '0;
            mem_dec[l]   <= '0;
            wb_commit[l] <= '0;
         end
      end else begin
         for (int l = 0; l < 2; l++) begin
            ex_dec[l]    <= take[l] ? dec[l] : '0;
            mem_dec[l]   <= ex_dec[l];
            wb_commit[l] <= mem_commit[l];
         end
      end
   end

   always_ff @(posedge gwe) begin
      for (int l = 0; l < 2; l++) begin
         ex_pc[l]       <= pair_pc[l];
         ex_insn[l]     <= pair_insn[l];
         ex_rs_data[l]  <= rs_data[l];
         ex_rt_data[l]  <= rt_data[l];
         mem_pc[l]      <= ex_pc[l];
         mem_insn[l]    <= ex_insn[l];
         mem_result[l]  <= alu_result[l];
         mem_rt_data[l] <= ex_rt_data[l];
      end
   end

   // memory stage builds the commit record; issue keeps loads and stores out of lane B
   always_comb begin
      for (int l = 0; l < 2; l++) begin
         mem_commit[l]         = '0;
         mem_commit[l].valid   = mem_dec[l].valid;
         mem_commit[l].pc      = mem_pc[l];
         mem_commit[l].insn    = mem_insn[l];
         mem_commit[l].rf_we   = mem_dec[l].rd_we;
         mem_commit[l].dmem_we = mem_dec[l].is_store;
         if (mem_dec[l].rd_we) begin
            mem_commit[l].wsel  = mem_dec[l].rd;
            mem_commit[l].wdata = mem_dec[l].is_load ? i_dmem_data : mem_result[l];
         end
         if (mem_dec[l].is_load || mem_dec[l].is_store) begin
            mem_commit[l].dmem_addr = mem_result[l];
            mem_commit[l].dmem_data = mem_dec[l].is_store ? mem_rt_data[l] : i_dmem_data;
         end
      end
   end

   assign o_dmem_addr    = mem_commit[0].dmem_addr;
   assign o_dmem_we      = mem_commit[0].dmem_we;    // one cycle per store
   assign o_dmem_towrite = mem_rt_data[0];

   assign o_commit_a = wb_commit[0];
   assign o_commit_b = wb_commit[1];

endmodule

`default_nettype wire
